//--- src/lane_state_pkg.sv
/*
  lane state definitions
  state encoding of the lane initialization FSM, lane data select codes and
  the mapping from each state to the ordered set it sends and expects back
*/
package lane_state_pkg;

  typedef enum logic [3:0] {
    DISABLED            = 4'b0000,
    CLD_CABLE_PROP      = 4'b0001,
    CLD_DET_DEVICE      = 4'b0010,
    CLD_PARAMETERS_1    = 4'b0011,
    CLD_PARAMETERS_2    = 4'b0100,
    CLD_CLK_SWITCH      = 4'b0101,
    TRAINING_GEN4_TS1   = 4'b0110,
    TRAINING_GEN4_TS2   = 4'b0111,
    TRAINING_GEN4_TS3   = 4'b1000,
    TRAINING_GEN4_TS4   = 4'b1001,
    TRAINING_GEN3_SLOS1 = 4'b1010,
    TRAINING_GEN3_SLOS2 = 4'b1011,
    TRAINING_GEN3_TS1   = 4'b1100,
    TRAINING_GEN3_TS2   = 4'b1101,
    CL0                 = 4'b1110
  } lane_state_t;

  // lane data select, also the code of a received ordered set on os_in
  typedef enum logic [3:0] {
    LANE_GEN3_SLOS1 = 4'd0,
    LANE_GEN3_SLOS2 = 4'd1,
    LANE_GEN3_TS1   = 4'd2,
    LANE_GEN3_TS2   = 4'd3,
    LANE_GEN4_TS1   = 4'd4,
    LANE_GEN4_TS2   = 4'd5,
    LANE_GEN4_TS3   = 4'd6,
    LANE_GEN4_TS4   = 4'd7,
    LANE_TRANSPORT  = 4'd8,
    LANE_ZEROS      = 4'd9
  } lane_sel_t;

  function automatic logic is_training_state(lane_state_t s);
    return (s >= TRAINING_GEN4_TS1) && (s <= TRAINING_GEN3_TS2);
  endfunction

  function automatic lane_sel_t state_lane_sel(lane_state_t s);
    case (s)
      TRAINING_GEN4_TS1:   return LANE_GEN4_TS1;
      TRAINING_GEN4_TS2:   return LANE_GEN4_TS2;
      TRAINING_GEN4_TS3:   return LANE_GEN4_TS3;
      TRAINING_GEN4_TS4:   return LANE_GEN4_TS4;
      TRAINING_GEN3_SLOS1: return LANE_GEN3_SLOS1;
      TRAINING_GEN3_SLOS2: return LANE_GEN3_SLOS2;
      TRAINING_GEN3_TS1:   return LANE_GEN3_TS1;
      TRAINING_GEN3_TS2:   return LANE_GEN3_TS2;
      CL0:                 return LANE_TRANSPORT;
      default:             return LANE_ZEROS; // nothing on the lanes before training
    endcase
  endfunction

endpackage

//--- src/link_param_pkg.sv
/*
  link parameter definitions
  generation encoding, config space address, capability bit positions in the
  cable word and in the far adapter payload, sideband transaction selects
*/
package link_param_pkg;

  typedef enum logic [1:0] {
    GEN4 = 2'b00,
    GEN3 = 2'b01,
    GEN2 = 2'b10
  } gen_t;

  localparam logic [7:0] CABLE_PROP_ADDR = 8'd18; // cable properties in config space
  localparam logic [7:0] USB4_ID         = 8'h40; // found in bits 7..0 of the cable word

  // 32-bit configuration word
  localparam int CABLE_GEN4_BIT = 21;
  localparam int CABLE_GEN3_BIT = 20;

  // 24-bit AT response payload
  localparam int ADAPTER_GEN4_BIT = 18;
  localparam int ADAPTER_GEN3_BIT = 13;

  typedef enum logic [2:0] {
    SEL_NONE       = 3'd0,
    SEL_AT_REQUEST = 3'd2
  } trans_sel_t;

endpackage

//--- src/lane_ctrl_if.sv
/*
  lane control interface
  carries the current lane state from the FSM to its helper blocks and
  returns the ordered-set result, the chosen speed and the cable check
*/
interface lane_ctrl_if;
  import lane_state_pkg::*;
  import link_param_pkg::*;

  lane_state_t state;      // current FSM state
  logic        state_hold; // next state equals current state
  logic        os_done;    // enough sets sent and the expected one seen
  gen_t        gen_speed;
  logic        is_usb4;

  modport fsm_mp (
    output state, state_hold,
    input  os_done, gen_speed, is_usb4
  );

  modport resolver_mp (output gen_speed, is_usb4, input state, state_hold);

  modport tracker_mp (output os_done, input state, state_hold);

  modport request_mp (input state);

endinterface

//--- src/lane_state_fsm.sv
/*
  lane state FSM
  walks the lane from DISABLED through the CLd sub-states and the training
  series into CL0, and registers the lane data select and status flags
*/
module lane_state_fsm (
  input  logic                      fsm_clk,
  input  logic                      reset_n,
  input  logic                      lane_disable_i,
  input  logic                      tdisabled_min_i,
  input  logic                      disconnect_sbrx_i,
  input  logic                      t_valid_i,
  input  logic                      trans_error_i,
  input  logic                      trans_sent_i,
  input  logic                      ttraining_error_timeout_i,
  input  logic                      tgen4_ts1_timeout_i,
  input  logic                      tgen4_ts2_timeout_i,
  lane_ctrl_if.fsm_mp               ctrl,
  output lane_state_pkg::lane_sel_t d_sel_o,
  output logic                      fsm_disabled_o,
  output logic                      fsm_training_o
);
  import lane_state_pkg::*;
  import link_param_pkg::*;

  lane_state_t state_q;
  lane_state_t state_d;
  logic        training_timeout;
  logic        link_up_state; // far side is expected to be present

  assign training_timeout = (is_training_state(state_q) && ttraining_error_timeout_i) ||
                            ((state_q == TRAINING_GEN4_TS1) && tgen4_ts1_timeout_i) ||
                            ((state_q == TRAINING_GEN4_TS2) && tgen4_ts2_timeout_i);

  assign link_up_state = (state_q >= CLD_PARAMETERS_1) && (state_q <= CL0);

  ////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      DISABLED:            if (tdisabled_min_i) state_d = CLD_CABLE_PROP; // min time in DISABLED
      CLD_CABLE_PROP:      if (ctrl.is_usb4) state_d = CLD_DET_DEVICE;
      CLD_DET_DEVICE:      if (!disconnect_sbrx_i) state_d = CLD_PARAMETERS_1;
      CLD_PARAMETERS_1:    if (t_valid_i && !trans_error_i) state_d = CLD_PARAMETERS_2;
      CLD_PARAMETERS_2:    if (trans_sent_i) state_d = CLD_CLK_SWITCH; // our AT response is out
      CLD_CLK_SWITCH:
      begin
        if (ctrl.gen_speed == GEN4)
          state_d = TRAINING_GEN4_TS1;
        else
          state_d = TRAINING_GEN3_SLOS1; // GEN2 uses the GEN3 series too
      end
      TRAINING_GEN4_TS1:   if (ctrl.os_done) state_d = TRAINING_GEN4_TS2;
      TRAINING_GEN4_TS2:   if (ctrl.os_done) state_d = TRAINING_GEN4_TS3;
      TRAINING_GEN4_TS3:   if (ctrl.os_done) state_d = TRAINING_GEN4_TS4;
      TRAINING_GEN4_TS4:   if (ctrl.os_done) state_d = CL0;
      TRAINING_GEN3_SLOS1: if (ctrl.os_done) state_d = TRAINING_GEN3_SLOS2;
      TRAINING_GEN3_SLOS2: if (ctrl.os_done) state_d = TRAINING_GEN3_TS1;
      TRAINING_GEN3_TS1:   if (ctrl.os_done) state_d = TRAINING_GEN3_TS2;
      TRAINING_GEN3_TS2:   if (ctrl.os_done) state_d = CL0;
      CL0:                 state_d = CL0;
      default:             state_d = DISABLED;
    endcase

    // exits in rising priority, last one wins
    if (training_timeout)
      state_d = CLD_PARAMETERS_1;
    if (disconnect_sbrx_i && link_up_state)
      state_d = CLD_DET_DEVICE;
    if (lane_disable_i)
      state_d = DISABLED;
  end

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= DISABLED;
    else
      state_q <= state_d;
  end

  assign ctrl.state      = state_q;
  assign ctrl.state_hold = (state_d == state_q);

  ////////////////////////////////////////////////////
  // registered lane select and status
  ////////////////////////////////////////////////////
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      d_sel_o        <= LANE_ZEROS;
      fsm_disabled_o <= 1'b1;
      fsm_training_o <= 1'b0;
    end
    else
    begin
      d_sel_o        <= state_lane_sel(state_q);
      fsm_disabled_o <= (state_q == DISABLED);
      fsm_training_o <= is_training_state(state_q);
    end
  end

  a_state_legal: assert property (
    @(posedge fsm_clk) disable iff (!reset_n) state_q <= CL0
  ) else $error("lane FSM left the legal state encodings");

endmodule

//--- src/cld_param_resolver.sv
/*
  CLd parameter resolver
  reads the cable properties, captures the far adapter generation from the
  AT response and settles on the slower of the two as the link speed
*/
module cld_param_resolver (
  input  logic                 fsm_clk,
  input  logic                 reset_n,
  input  logic [31:0]          c_data_i,
  input  logic [23:0]          payload_i,
  input  logic                 t_valid_i,
  input  logic                 trans_error_i,
  lane_ctrl_if.resolver_mp     ctrl,
  output logic [7:0]           c_address_o,
  output logic                 c_read_write_o,
  output link_param_pkg::gen_t gen_speed_o
);
  import lane_state_pkg::*;
  import link_param_pkg::*;

  gen_t cable_gen_q;
  gen_t far_gen_q;
  gen_t gen_speed_q;
  logic is_usb4_q;

  // highest generation advertised by a pair of capability bits
  function automatic gen_t gen_from_bits(logic gen4_bit, logic gen3_bit);
    if (gen4_bit)
      return GEN4;
    else if (gen3_bit)
      return GEN3;
    else
      return GEN2;
  endfunction

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cable_gen_q    <= GEN4;
      far_gen_q      <= GEN4;
      gen_speed_q    <= GEN4;
      is_usb4_q      <= 1'b0;
      c_address_o    <= 8'h00;
      c_read_write_o <= 1'b1;
    end
    else
    begin
      case (ctrl.state)
        DISABLED:
        begin
          cable_gen_q    <= GEN4;
          far_gen_q      <= GEN4;
          gen_speed_q    <= GEN4;
          is_usb4_q      <= 1'b0;
          c_address_o    <= 8'h00;
          c_read_write_o <= 1'b1;
        end
        CLD_CABLE_PROP:
        begin
          c_address_o    <= CABLE_PROP_ADDR;
          c_read_write_o <= 1'b1; // read
          if (ctrl.state_hold)
          begin
            is_usb4_q   <= (c_data_i[7:0] == USB4_ID);
            cable_gen_q <= gen_from_bits(c_data_i[CABLE_GEN4_BIT], c_data_i[CABLE_GEN3_BIT]);
          end
        end
        CLD_PARAMETERS_1:
        begin
          if (t_valid_i && !trans_error_i) // clean AT response from the far adapter
            far_gen_q <= gen_from_bits(payload_i[ADAPTER_GEN4_BIT], payload_i[ADAPTER_GEN3_BIT]);
        end
        CLD_PARAMETERS_2:
          gen_speed_q <= (cable_gen_q > far_gen_q) ? cable_gen_q : far_gen_q; // larger is slower
        default:
        begin
        end
      endcase
    end
  end

  assign ctrl.gen_speed = gen_speed_q;
  assign ctrl.is_usb4   = is_usb4_q;
  assign gen_speed_o    = gen_speed_q;

  a_gen_speed_legal: assert property (
    @(posedge fsm_clk) disable iff (!reset_n) gen_speed_q != 2'b11
  ) else $error("gen_speed holds the unused encoding");

endmodule

//--- src/os_exchange_tracker.sv
/*
  ordered-set exchange tracker
  counts the sets sent in the current training state and remembers whether
  the far side has answered with the same set
*/
module os_exchange_tracker #(
  parameter int OS_CNT_GEN4 = 16,
  parameter int OS_CNT_GEN3 = 32
) (
  input  logic            fsm_clk,
  input  logic            reset_n,
  input  logic            os_sent_i,
  input  logic [3:0]      os_in_i,
  lane_ctrl_if.tracker_mp ctrl
);
  import lane_state_pkg::*;

  localparam int CNT_MAX = (OS_CNT_GEN4 > OS_CNT_GEN3) ? OS_CNT_GEN4 : OS_CNT_GEN3;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  logic [CNT_W-1:0] os_cnt_q;
  logic [CNT_W-1:0] os_target;
  logic             in_training;
  logic             gen4_series;
  logic             count_reached;
  logic             os_match;
  logic             os_match_q;
  logic             os_done_q;

  assign in_training   = is_training_state(ctrl.state);
  assign gen4_series   = (ctrl.state >= TRAINING_GEN4_TS1) && (ctrl.state <= TRAINING_GEN4_TS4);
  assign os_target     = gen4_series ? CNT_W'(OS_CNT_GEN4) : CNT_W'(OS_CNT_GEN3);
  assign count_reached = (os_cnt_q >= os_target);
  assign os_match      = (os_in_i == state_lane_sel(ctrl.state)); // far side sends the same set

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      os_cnt_q   <= '0;
      os_match_q <= 1'b0;
      os_done_q  <= 1'b0;
    end
    else if (!in_training || !ctrl.state_hold) // fresh start on every state change
    begin
      os_cnt_q   <= '0;
      os_match_q <= 1'b0;
      os_done_q  <= 1'b0;
    end
    else
    begin
      if (os_sent_i && !count_reached)
        os_cnt_q <= os_cnt_q + 1'b1; // saturates at the target
      if (os_match)
        os_match_q <= 1'b1;
      os_done_q <= count_reached && (os_match_q || os_match);
    end
  end

  assign ctrl.os_done = os_done_q;

  a_cnt_idle: assert property (
    @(posedge fsm_clk) disable iff (!reset_n) !in_training |-> (os_cnt_q == '0)
  ) else $error("ordered-set count is nonzero outside training");

endmodule

//--- src/at_request_ctrl.sv
/*
  AT request control
  issues the one-shot parameter request in CLD_PARAMETERS_1, repeats it
  after a bad response, and drives the sideband disconnect level
*/
module at_request_ctrl (
  input  logic                       fsm_clk,
  input  logic                       reset_n,
  input  logic                       trans_error_i,
  lane_ctrl_if.request_mp            ctrl,
  output link_param_pkg::trans_sel_t trans_sel_o,
  output logic                       disconnect_sbtx_o
);
  import lane_state_pkg::*;
  import link_param_pkg::*;

  logic in_params;
  logic send_q;  // request armed one cycle after entry
  logic sent_q;  // request already issued in this visit
  logic issue;

  assign in_params = (ctrl.state == CLD_PARAMETERS_1);
  assign issue     = in_params && ((send_q && !sent_q) || trans_error_i); // error means retry

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      send_q            <= 1'b0;
      sent_q            <= 1'b0;
      trans_sel_o       <= SEL_NONE;
      disconnect_sbtx_o <= 1'b1; // zeros on sbtx
    end
    else
    begin
      send_q            <= in_params;
      sent_q            <= in_params && (sent_q || issue);
      trans_sel_o       <= issue ? SEL_AT_REQUEST : SEL_NONE;
      disconnect_sbtx_o <= (ctrl.state == DISABLED) || (ctrl.state == CLD_CABLE_PROP);
    end
  end

  a_trans_sel_legal: assert property (
    @(posedge fsm_clk) disable iff (!reset_n) trans_sel_o inside {SEL_NONE, SEL_AT_REQUEST}
  ) else $error("unexpected transaction select");

endmodule

//--- src/lane_init_top.sv
/*
  lane initialization top level
  connects the lane FSM to the parameter resolver, the ordered-set tracker
  and the AT request control over one lane control interface
*/
module lane_init_top #(
  parameter int OS_CNT_GEN4 = 16,
  parameter int OS_CNT_GEN3 = 32
) (
  input  logic        fsm_clk,
  input  logic        reset_n,
  input  logic [3:0]  os_in_i,
  input  logic        disconnect_sbrx_i,
  input  logic [23:0] payload_i,
  input  logic        trans_error_i,
  input  logic        t_valid_i,
  input  logic        os_sent_i,
  input  logic [31:0] c_data_i,
  input  logic        lane_disable_i,
  input  logic        tdisabled_min_i,
  input  logic        ttraining_error_timeout_i,
  input  logic        tgen4_ts1_timeout_i,
  input  logic        tgen4_ts2_timeout_i,
  input  logic        trans_sent_i,
  output logic [2:0]  trans_sel_o,
  output logic        disconnect_sbtx_o,
  output logic        fsm_disabled_o,
  output logic        fsm_training_o,
  output logic [3:0]  d_sel_o,
  output logic [1:0]  gen_speed_o,
  output logic [7:0]  c_address_o,
  output logic        c_read_write_o
);

  lane_ctrl_if ctrl_if ();

  lane_state_fsm u_fsm (
    .fsm_clk                   (fsm_clk),
    .reset_n                   (reset_n),
    .lane_disable_i            (lane_disable_i),
    .tdisabled_min_i           (tdisabled_min_i),
    .disconnect_sbrx_i         (disconnect_sbrx_i),
    .t_valid_i                 (t_valid_i),
    .trans_error_i             (trans_error_i),
    .trans_sent_i              (trans_sent_i),
    .ttraining_error_timeout_i (ttraining_error_timeout_i),
    .tgen4_ts1_timeout_i       (tgen4_ts1_timeout_i),
    .tgen4_ts2_timeout_i       (tgen4_ts2_timeout_i),
    .ctrl                      (ctrl_if),
    .d_sel_o                   (d_sel_o),
    .fsm_disabled_o            (fsm_disabled_o),
    .fsm_training_o            (fsm_training_o)
  );

  cld_param_resolver u_resolver (
    .fsm_clk        (fsm_clk),
    .reset_n        (reset_n),
    .c_data_i       (c_data_i),
    .payload_i      (payload_i),
    .t_valid_i      (t_valid_i),
    .trans_error_i  (trans_error_i),
    .ctrl           (ctrl_if),
    .c_address_o    (c_address_o),
    .c_read_write_o (c_read_write_o),
    .gen_speed_o    (gen_speed_o)
  );

  os_exchange_tracker #(
    .OS_CNT_GEN4 (OS_CNT_GEN4),
    .OS_CNT_GEN3 (OS_CNT_GEN3)
  ) u_tracker (
    .fsm_clk   (fsm_clk),
    .reset_n   (reset_n),
    .os_sent_i (os_sent_i),
    .os_in_i   (os_in_i),
    .ctrl      (ctrl_if)
  );

  at_request_ctrl u_request (
    .fsm_clk           (fsm_clk),
    .reset_n           (reset_n),
    .trans_error_i     (trans_error_i),
    .ctrl              (ctrl_if),
    .trans_sel_o       (trans_sel_o),
    .disconnect_sbtx_o (disconnect_sbtx_o)
  );

endmodule

//--- include/lane_init_tests.svh
/*
  lane initialization directed tests
  stimulus helpers, bounded waits and the test tasks of the testbench
*/
`ifndef LANE_INIT_TESTS_SVH
`define LANE_INIT_TESTS_SVH

//////////////////////////////////////////////////
// bounded waits
//////////////////////////////////////////////////
task automatic wait_dsel(input logic [3:0] expected, input int limit);
  int n;
  n = 0;
  while (d_sel_o !== expected && n < limit)
  begin
    tick();
    n++;
  end
  if (d_sel_o !== expected)
  begin
    error_count++;
    $display("timeout at %0t: d_sel_o did not reach %0d within %0d cycles",
             $time, expected, limit);
  end
endtask

task automatic wait_disabled_flag(input logic expected, input int limit);
  int n;
  n = 0;
  while (fsm_disabled_o !== expected && n < limit)
  begin
    tick();
    n++;
  end
  if (fsm_disabled_o !== expected)
  begin
    error_count++;
    $display("timeout at %0t: fsm_disabled_o did not become %0d within %0d cycles",
             $time, expected, limit);
  end
endtask

task automatic wait_request(input int limit);
  int n;
  n = 0;
  while (trans_sel_o !== REQ_AT && n < limit)
  begin
    tick();
    n++;
  end
  if (trans_sel_o !== REQ_AT)
  begin
    error_count++;
    $display("timeout at %0t: no AT request was issued within %0d cycles", $time, limit);
  end
endtask

//////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////
function automatic logic [31:0] make_cable(input logic usb4, input logic g4, input logic g3);
  logic [31:0] w;
  w = $urandom();
  if (usb4)
    w[7:0] = 8'h40;
  else if (w[7:0] == 8'h40)
    w[7:0] = 8'h41; // keep the identifier out
  w[21] = g4;
  w[20] = g3;
  return w;
endfunction

function automatic logic [23:0] make_payload(input logic g4, input logic g3);
  logic [31:0] r;
  r = $urandom();
  r[18] = g4;
  r[13] = g3;
  return r[23:0];
endfunction

task automatic check_no_request(input int cycles);
  repeat (cycles)
  begin
    tick();
    check_value(trans_sel_o, REQ_NONE, "no further AT request");
  end
endtask

task automatic leave_disabled();
  tdisabled_min_i = 1'b1;
  wait_disabled_flag(1'b0, 6);
  tdisabled_min_i = 1'b0;
  check_value(c_address_o, CABLE_ADDR, "cable property address");
  check_value(c_read_write_o, 1'b1, "cable read flag");
endtask

// reset, cable read, request and parameter exchange up to the clock switch
task automatic bring_up(input logic [31:0] cable, input logic [23:0] payload);
  apply_reset();
  leave_disabled();
  c_data_i          = cable;
  disconnect_sbrx_i = 1'b0;
  wait_request(10);
  payload_i = payload;
  t_valid_i = 1'b1;
  tick();
  t_valid_i    = 1'b0;
  trans_sent_i = 1'b1;
  tick();
  trans_sent_i = 1'b0;
endtask

task automatic send_os(input logic [3:0] code, input int count);
  os_in_i = code;
  repeat (count)
  begin
    os_sent_i = 1'b1;
    tick();
  end
  os_sent_i = 1'b0;
endtask

task automatic run_series(input logic [3:0] first_code, input int count);
  logic [3:0] code;
  for (int i = 0; i < 4; i++)
  begin
    code = first_code + 4'(i);
    check_value(d_sel_o, code, "lane select on entry to training state");
    check_value(fsm_training_o, 1'b1, "training flag");
    send_os(code, count - 1);
    repeat (4) tick();
    check_value(d_sel_o, code, "lane select held one set short of the count");
    send_os(code, 1);
    os_in_i = SEL_ZEROS;
    wait_dsel((i == 3) ? SEL_TRANSPORT : code + 4'd1, 8);
  end
  check_value(fsm_training_o, 1'b0, "training flag in CL0");
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////
task automatic test_reset_disabled();
  int errs;
  errs = error_count;
  apply_reset();
  check_value(d_sel_o, SEL_ZEROS, "lane select after reset");
  check_value(fsm_disabled_o, 1'b1, "disabled flag after reset");
  check_value(fsm_training_o, 1'b0, "training flag after reset");
  check_value(trans_sel_o, REQ_NONE, "transaction select after reset");
  check_value(disconnect_sbtx_o, 1'b1, "sideband disconnect after reset");
  check_value(c_read_write_o, 1'b1, "read flag after reset");
  check_value(c_address_o, 8'd0, "config address after reset");
  check_value(gen_speed_o, GEN4_CODE, "speed after reset");
  repeat (10)
  begin
    tick();
    check_value(d_sel_o, SEL_ZEROS, "lane select held in DISABLED");
    check_value(fsm_disabled_o, 1'b1, "disabled flag held in DISABLED");
  end
  leave_disabled();
  finish_test("reset and DISABLED", errs);
endtask

task automatic test_cable_gate_request();
  int errs;
  errs = error_count;
  apply_reset();
  leave_disabled();
  c_data_i          = make_cable(1'b0, 1'b1, 1'b0);
  disconnect_sbrx_i = 1'b0;
  repeat (8)
  begin
    tick();
    check_value(c_address_o, CABLE_ADDR, "address held on a non USB4 cable");
    check_value(disconnect_sbtx_o, 1'b1, "sideband disconnect during cable read");
    check_value(trans_sel_o, REQ_NONE, "no request on a non USB4 cable");
  end
  c_data_i = make_cable(1'b1, 1'b1, 1'b0);
  wait_request(10);
  check_no_request(4);
  check_value(disconnect_sbtx_o, 1'b0, "sideband disconnect released");
  trans_error_i = 1'b1;
  tick();
  trans_error_i = 1'b0;
  check_value(trans_sel_o, REQ_AT, "request repeated after an error");
  check_no_request(4);
  finish_test("cable gate and AT request", errs);
endtask

task automatic test_gen4_training();
  int errs;
  errs = error_count;
  bring_up(make_cable(1'b1, 1'b1, 1'b0), make_payload(1'b1, 1'b0));
  wait_dsel(4'd4, 6);
  check_value(gen_speed_o, GEN4_CODE, "GEN4 speed");
  run_series(4'd4, OS_CNT_GEN4);
  finish_test("GEN4 training", errs);
endtask

task automatic test_gen3_gen2_training();
  int errs;
  errs = error_count;
  bring_up(make_cable(1'b1, 1'b1, 1'b0), make_payload(1'b0, 1'b1));
  wait_dsel(4'd0, 6);
  check_value(gen_speed_o, GEN3_CODE, "GEN3 from the far adapter");
  run_series(4'd0, OS_CNT_GEN3);
  bring_up(make_cable(1'b1, 1'b0, 1'b0), make_payload(1'b1, 1'b1));
  wait_dsel(4'd0, 6);
  check_value(gen_speed_o, GEN2_CODE, "GEN2 from the cable");
  run_series(4'd0, OS_CNT_GEN3);
  finish_test("speed resolution and GEN3 series", errs);
endtask

task automatic test_timeout_recovery();
  int errs;
  errs = error_count;
  bring_up(make_cable(1'b1, 1'b1, 1'b0), make_payload(1'b1, 1'b0));
  wait_dsel(4'd4, 6);
  send_os(SEL_ZEROS, OS_CNT_GEN4); // count reached with no matching set
  repeat (6) tick();
  check_value(d_sel_o, 4'd4, "no advance without a matching set");
  tgen4_ts1_timeout_i = 1'b1;
  tick();
  tgen4_ts1_timeout_i = 1'b0;
  wait_dsel(SEL_ZEROS, 5);
  check_value(fsm_training_o, 1'b0, "training flag after timeout");
  wait_request(6);
  finish_test("timeout recovery", errs);
endtask

task automatic test_cl0_exits();
  int errs;
  errs = error_count;
  bring_up(make_cable(1'b1, 1'b1, 1'b0), make_payload(1'b1, 1'b0));
  wait_dsel(4'd4, 6);
  run_series(4'd4, OS_CNT_GEN4);
  disconnect_sbrx_i = 1'b1;
  wait_dsel(SEL_ZEROS, 5);
  repeat (4)
  begin
    tick();
    check_value(c_address_o, CABLE_ADDR, "address kept after disconnect");
    check_value(disconnect_sbtx_o, 1'b0, "no new cable read after disconnect");
    check_value(fsm_disabled_o, 1'b0, "not disabled after disconnect");
  end
  lane_disable_i = 1'b1;
  wait_disabled_flag(1'b1, 5);
  check_value(disconnect_sbtx_o, 1'b1, "sideband disconnect in DISABLED");
  lane_disable_i = 1'b0;
  finish_test("exits from CL0", errs);
endtask

`endif

//--- test/lane_init_tb.sv
/*
  lane initialization testbench
  runs directed tests against lane_init_top, one result line per test
*/
module lane_init_tb;

  localparam int         OS_CNT_GEN4   = 16; // same as the DUT defaults
  localparam int         OS_CNT_GEN3   = 32;
  localparam logic [3:0] SEL_ZEROS     = 4'd9;
  localparam logic [3:0] SEL_TRANSPORT = 4'd8;
  localparam logic [2:0] REQ_NONE      = 3'd0;
  localparam logic [2:0] REQ_AT        = 3'd2;
  localparam logic [7:0] CABLE_ADDR    = 8'd18;
  localparam logic [1:0] GEN4_CODE     = 2'd0;
  localparam logic [1:0] GEN3_CODE     = 2'd1;
  localparam logic [1:0] GEN2_CODE     = 2'd2;

  logic        fsm_clk;
  logic        reset_n;
  logic [3:0]  os_in_i;
  logic        disconnect_sbrx_i;
  logic [23:0] payload_i;
  logic        trans_error_i;
  logic        t_valid_i;
  logic        os_sent_i;
  logic [31:0] c_data_i;
  logic        lane_disable_i;
  logic        tdisabled_min_i;
  logic        ttraining_error_timeout_i;
  logic        tgen4_ts1_timeout_i;
  logic        tgen4_ts2_timeout_i;
  logic        trans_sent_i;
  logic [2:0]  trans_sel_o;
  logic        disconnect_sbtx_o;
  logic        fsm_disabled_o;
  logic        fsm_training_o;
  logic [3:0]  d_sel_o;
  logic [1:0]  gen_speed_o;
  logic [7:0]  c_address_o;
  logic        c_read_write_o;

  int error_count;
  int check_count;
  int test_count;
  int failed_tests;

  initial
  begin
    fsm_clk = 1'b0;
    forever #10 fsm_clk = ~fsm_clk; // period 20
  end

  lane_init_top dut_i (
    .fsm_clk                   (fsm_clk),
    .reset_n                   (reset_n),
    .os_in_i                   (os_in_i),
    .disconnect_sbrx_i         (disconnect_sbrx_i),
    .payload_i                 (payload_i),
    .trans_error_i             (trans_error_i),
    .t_valid_i                 (t_valid_i),
    .os_sent_i                 (os_sent_i),
    .c_data_i                  (c_data_i),
    .lane_disable_i            (lane_disable_i),
    .tdisabled_min_i           (tdisabled_min_i),
    .ttraining_error_timeout_i (ttraining_error_timeout_i),
    .tgen4_ts1_timeout_i       (tgen4_ts1_timeout_i),
    .tgen4_ts2_timeout_i       (tgen4_ts2_timeout_i),
    .trans_sent_i              (trans_sent_i),
    .trans_sel_o               (trans_sel_o),
    .disconnect_sbtx_o         (disconnect_sbtx_o),
    .fsm_disabled_o            (fsm_disabled_o),
    .fsm_training_o            (fsm_training_o),
    .d_sel_o                   (d_sel_o),
    .gen_speed_o               (gen_speed_o),
    .c_address_o               (c_address_o),
    .c_read_write_o            (c_read_write_o)
  );

  //////////////////////////////////////////////////
  // basic helpers
  //////////////////////////////////////////////////
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[FAIL] %0t: %s: got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task automatic tick();
    @(posedge fsm_clk);
    #2; // inputs change and outputs are read here
  endtask

  task automatic apply_reset();
    reset_n                   = 1'b0;
    os_in_i                   = SEL_ZEROS; // matches no training state
    disconnect_sbrx_i         = 1'b1;      // no device yet
    payload_i                 = '0;
    trans_error_i             = 1'b0;
    t_valid_i                 = 1'b0;
    os_sent_i                 = 1'b0;
    c_data_i                  = '0;
    lane_disable_i            = 1'b0;
    tdisabled_min_i           = 1'b0;
    ttraining_error_timeout_i = 1'b0;
    tgen4_ts1_timeout_i       = 1'b0;
    tgen4_ts2_timeout_i       = 1'b0;
    trans_sent_i              = 1'b0;
    repeat (4) tick();
    reset_n = 1'b1;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
    begin
      $display("test %s: ok", name);
    end
    else
    begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  `include "lane_init_tests.svh"

  initial
  begin
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    void'($urandom(32'hfe197c0d));
    test_reset_disabled();
    test_cable_gate_request();
    test_gen4_training();
    test_gen3_gen2_training();
    test_timeout_recovery();
    test_cl0_exits();
    $display("tests: %0d run, %0d failed, checks: %0d, errors: %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
src/lane_state_pkg.sv
src/link_param_pkg.sv
src/lane_ctrl_if.sv
src/lane_state_fsm.sv
src/cld_param_resolver.sv
src/os_exchange_tracker.sv
src/at_request_ctrl.sv
src/lane_init_top.sv
test/lane_init_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lane initialization testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module lane_init_tb -f src.f -o lane_init_sim

./obj_dir/lane_init_sim | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
